/* include/pruneArray_params.svh */
// width, depth and sweep constants of the block-pruning datapath, included by the RTL and the testbench
`ifndef PRUNE_ARRAY_PARAMS_SVH
`define PRUNE_ARRAY_PARAMS_SVH

// ----------------------------------------------------------------------
// score format
// ----------------------------------------------------------------------

// one importance score is an unsigned word of this many bits
`define SCORE_WIDTH 16

// every strobe delivers this many scores per row
`define TILE_SIZE 4

// ----------------------------------------------------------------------
// storage and sweep
// ----------------------------------------------------------------------

// entries held by each row store, and so bits in each keep-mask
`define STORE_DEPTH 64

// mask bits written per sweep cycle
`define CHUNK_SIZE 16
`define CHUNK_COUNT (`STORE_DEPTH / `CHUNK_SIZE)
`define CHUNK_INDEX_WIDTH ($clog2(`CHUNK_COUNT))

// pruning ratio is counted in eighths of the min to max spread
`define RATIO_WIDTH 3
`define RATIO_SHIFT 3

`endif

/* hw/pruneArrayPkg.sv */
// shared score, tile, chunk and mask types, imported by every block of the pruning datapath
`include "pruneArray_params.svh"

package pruneArrayPkg;

	// ----------------------------------------------------------------------
	// score words
	// ----------------------------------------------------------------------

	// unsigned importance score as produced for one tile position
	typedef logic [`SCORE_WIDTH-1:0] score_t;

	// the four scores of one row that arrive with a single strobe
	typedef score_t [`TILE_SIZE-1:0] tile_t;

	// sixteen consecutive store entries, judged in one sweep cycle
	typedef score_t [`CHUNK_SIZE-1:0] chunk_t;

	// ----------------------------------------------------------------------
	// control and results
	// ----------------------------------------------------------------------

	// one bit per store entry, a one keeps the block
	typedef logic [`STORE_DEPTH-1:0] mask_t;

	// block pruning ratio in eighths
	typedef logic [`RATIO_WIDTH-1:0] ratio_t;

	// entry index into one row store
	typedef logic [$clog2(`STORE_DEPTH)-1:0] storeIndex_t;

endpackage

/* hw/rowImportanceTracker.sv */
// running per-row min/max and head sum tracker, raises rowDone at end of row and decides head pruning
`timescale 1ns/1ps
`include "pruneArray_params.svh"

module rowImportanceTracker
	import pruneArrayPkg::*;
(
	input  logic   clk,
	input  logic   _resetRow,
	input  logic   _resetHead,
	input  logic   scoreValid,
	input  logic   endOfRow,
	input  logic   endOfHead,
	input  tile_t  scoresRow0,
	input  tile_t  scoresRow1,
	input  score_t headThreshold,
	output score_t rowMin0,
	output score_t rowMax0,
	output score_t rowMin1,
	output score_t rowMax1,
	output score_t sumHeadFinal,
	output logic   rowDone,
	output logic   pruneHead
);

	// head sum keeps running across rows and is only cleared by the head reset
	score_t sumHead;

	// values the registers take when the current tile is accepted
	score_t nextMin0;
	score_t nextMax0;
	score_t nextMin1;
	score_t nextMax1;
	score_t sumHeadNext;

	// ----------------------------------------------------------------------
	// tile folding helpers
	// ----------------------------------------------------------------------

	// smallest of the four tile scores and the running minimum
	function automatic score_t foldMin(input tile_t tile, input score_t current);
		score_t result;
		result = current;
		for (int k = 0; k < `TILE_SIZE; k++)
		begin
			if (tile[k] < result)
				result = tile[k];
		end
		return result;
	endfunction

	// largest of the four tile scores and the running maximum
	function automatic score_t foldMax(input tile_t tile, input score_t current);
		score_t result;
		result = current;
		for (int k = 0; k < `TILE_SIZE; k++)
		begin
			if (tile[k] > result)
				result = tile[k];
		end
		return result;
	endfunction

	// sum of one row's tile, wrapping at the score width like the head sum
	function automatic score_t tileSum(input tile_t tile);
		score_t result;
		result = '0;
		for (int k = 0; k < `TILE_SIZE; k++)
			result = result + tile[k];
		return result;
	endfunction

	always_comb
	begin
		nextMin0 = foldMin(scoresRow0, rowMin0);
		nextMax0 = foldMax(scoresRow0, rowMax0);
		nextMin1 = foldMin(scoresRow1, rowMin1);
		nextMax1 = foldMax(scoresRow1, rowMax1);
		// both rows of the tile count towards the head
		sumHeadNext = sumHead + tileSum(scoresRow0) + tileSum(scoresRow1);
	end

	// ----------------------------------------------------------------------
	// row statistics, cleared by either reset
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge _resetRow or negedge _resetHead)
	begin
		if (!_resetRow || !_resetHead)
		begin
			// minimum starts at the top of the range so the first score always wins
			rowMin0 <= '1;
			rowMax0 <= '0;
			rowMin1 <= '1;
			rowMax1 <= '0;
			rowDone <= 1'b0;
		end
		else
		begin
			// the generators see the final min/max together with this pulse
			rowDone <= scoreValid && endOfRow;
			if (scoreValid)
			begin
				rowMin0 <= nextMin0;
				rowMax0 <= nextMax0;
				rowMin1 <= nextMin1;
				rowMax1 <= nextMax1;
			end
		end
	end

	// ----------------------------------------------------------------------
	// head sum and pruning decision, cleared by the head reset only
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge _resetHead)
	begin
		if (!_resetHead)
		begin
			sumHead <= '0;
			sumHeadFinal <= '0;
			pruneHead <= 1'b0;
		end
		else if (scoreValid)
		begin
			sumHead <= sumHeadNext;
			if (endOfRow)
			begin
				// the reported sum already includes the closing tile
				sumHeadFinal <= sumHeadNext;
				// a head whose total importance stays at or below the limit is dropped
				if (endOfHead)
					pruneHead <= (sumHeadNext <= headThreshold);
			end
		end
	end

endmodule

/* hw/importanceStore.sv */
// per-row score memory, written a tile at a time and read back as 16-entry chunks for the mask sweep
`timescale 1ns/1ps
`include "pruneArray_params.svh"

module importanceStore
	import pruneArrayPkg::*;
(
	input  logic                          clk,
	input  logic                          _resetRow,
	input  logic                          _resetHead,
	input  logic                          scoreValid,
	input  tile_t                         scores,
	input  logic [`CHUNK_INDEX_WIDTH-1:0] chunkIndex,
	output chunk_t                        chunkScores
);

	// scores in arrival order, entry zero is the first score of the row
	score_t storage [`STORE_DEPTH];

	// next free entry, always a multiple of the tile size
	storeIndex_t writePtr;

	// set once the last tile slot is taken, later tiles are dropped
	logic storeFull;

	// first entry of the chunk the generator is asking for
	storeIndex_t chunkBase;

	// ----------------------------------------------------------------------
	// write side
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge _resetRow or negedge _resetHead)
	begin
		if (!_resetRow || !_resetHead)
		begin
			// unwritten entries read as zero during the sweep
			for (int e = 0; e < `STORE_DEPTH; e++)
				storage[e] <= '0;
			writePtr <= '0;
			storeFull <= 1'b0;
		end
		else if (scoreValid && !storeFull)
		begin
			for (int k = 0; k < `TILE_SIZE; k++)
				storage[writePtr + storeIndex_t'(k)] <= scores[k];
			writePtr <= writePtr + storeIndex_t'(`TILE_SIZE);
			// the pointer wraps here so the flag is what marks the store as full
			if (writePtr == storeIndex_t'(`STORE_DEPTH - `TILE_SIZE))
				storeFull <= 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// chunk read port
	// ----------------------------------------------------------------------

	assign chunkBase = storeIndex_t'(chunkIndex * `CHUNK_SIZE);

	// combinational read, the generator registers the comparison result
	always_comb
	begin
		for (int k = 0; k < `CHUNK_SIZE; k++)
			chunkScores[k] = storage[chunkBase + storeIndex_t'(k)];
	end

endmodule

/* hw/blockMaskGenerator.sv */
// row threshold calculation and chunked sweep of one row store into that row's keep-mask
`timescale 1ns/1ps
`include "pruneArray_params.svh"

module blockMaskGenerator
	import pruneArrayPkg::*;
(
	input  logic                          clk,
	input  logic                          _resetRow,
	input  logic                          _resetHead,
	input  logic                          rowDone,
	input  score_t                        rowMin,
	input  score_t                        rowMax,
	input  ratio_t                        blockPruningRatio,
	input  chunk_t                        chunkScores,
	output logic [`CHUNK_INDEX_WIDTH-1:0] chunkIndex,
	output mask_t                         mask,
	output logic                          maskBusy
);

	// threshold held for the whole sweep of the row
	score_t threshold;

	// threshold terms computed from the row statistics
	score_t spread;
	logic [`SCORE_WIDTH+`RATIO_WIDTH-1:0] weightedSpread;
	score_t thresholdNext;

	// keep bits for the chunk currently on the read port
	logic [`CHUNK_SIZE-1:0] chunkKeep;

	// ----------------------------------------------------------------------
	// threshold
	// ----------------------------------------------------------------------

	// threshold sits the given number of eighths of the way from min to max
	// and so never exceeds the row maximum
	always_comb
	begin
		spread = rowMax - rowMin;
		weightedSpread = spread * blockPruningRatio;
		thresholdNext = rowMin + score_t'(weightedSpread >> `RATIO_SHIFT);
	end

	always_ff @(posedge clk)
	begin
		if (rowDone)
			threshold <= thresholdNext;
	end

	// ----------------------------------------------------------------------
	// chunk comparison
	// ----------------------------------------------------------------------

	// a block is kept when its score reaches the threshold
	// zero entries that were never written follow the same rule
	always_comb
	begin
		for (int k = 0; k < `CHUNK_SIZE; k++)
			chunkKeep[k] = (chunkScores[k] >= threshold);
	end

	// ----------------------------------------------------------------------
	// sweep control
	// ----------------------------------------------------------------------

	// rowDone starts the sweep one edge later, then one chunk lands per edge
	// and busy drops on the edge that writes the last chunk
	always_ff @(posedge clk or negedge _resetRow or negedge _resetHead)
	begin
		if (!_resetRow || !_resetHead)
		begin
			// an idle mask keeps every block
			mask <= '1;
			chunkIndex <= '0;
			maskBusy <= 1'b0;
		end
		else if (maskBusy)
		begin
			mask[chunkIndex * `CHUNK_SIZE +: `CHUNK_SIZE] <= chunkKeep;
			// the index wraps back to zero after the last chunk
			chunkIndex <= chunkIndex + 1'b1;
			if (int'(chunkIndex) == `CHUNK_COUNT - 1)
				maskBusy <= 1'b0;
		end
		else if (rowDone)
		begin
			chunkIndex <= '0;
			maskBusy <= 1'b1;
		end
	end

endmodule

/* hw/pruneArray.sv */
// top level of the block-pruning datapath, wires the tracker to two row stores and two mask generators
`timescale 1ns/1ps
`include "pruneArray_params.svh"

module pruneArray
	import pruneArrayPkg::*;
(
	input  logic   clk,
	input  logic   _resetRow,
	input  logic   _resetHead,
	input  logic   scoreValid,
	input  logic   endOfRow,
	input  logic   endOfHead,
	input  tile_t  scoresRow0,
	input  tile_t  scoresRow1,
	input  score_t headThreshold,
	input  ratio_t blockPruningRatio,
	output mask_t  mask0,
	output mask_t  mask1,
	output logic   maskBusy,
	output logic   pruneHead,
	output score_t sumHeadFinal
);

	// row statistics handed to the generators with the end of row pulse
	logic   rowDone;
	score_t rowMin0;
	score_t rowMax0;
	score_t rowMin1;
	score_t rowMax1;

	// chunk read ports between each generator and its store
	logic [`CHUNK_INDEX_WIDTH-1:0] chunkIndex0;
	logic [`CHUNK_INDEX_WIDTH-1:0] chunkIndex1;
	chunk_t chunkScores0;
	chunk_t chunkScores1;

	// ----------------------------------------------------------------------
	// statistics
	// ----------------------------------------------------------------------

	rowImportanceTracker tracker (
		.clk           (clk),
		._resetRow     (_resetRow),
		._resetHead    (_resetHead),
		.scoreValid    (scoreValid),
		.endOfRow      (endOfRow),
		.endOfHead     (endOfHead),
		.scoresRow0    (scoresRow0),
		.scoresRow1    (scoresRow1),
		.headThreshold (headThreshold),
		.rowMin0       (rowMin0),
		.rowMax0       (rowMax0),
		.rowMin1       (rowMin1),
		.rowMax1       (rowMax1),
		.sumHeadFinal  (sumHeadFinal),
		.rowDone       (rowDone),
		.pruneHead     (pruneHead)
	);

	// ----------------------------------------------------------------------
	// per-row storage
	// ----------------------------------------------------------------------

	importanceStore storeRow0 (
		.clk         (clk),
		._resetRow   (_resetRow),
		._resetHead  (_resetHead),
		.scoreValid  (scoreValid),
		.scores      (scoresRow0),
		.chunkIndex  (chunkIndex0),
		.chunkScores (chunkScores0)
	);

	importanceStore storeRow1 (
		.clk         (clk),
		._resetRow   (_resetRow),
		._resetHead  (_resetHead),
		.scoreValid  (scoreValid),
		.scores      (scoresRow1),
		.chunkIndex  (chunkIndex1),
		.chunkScores (chunkScores1)
	);

	// ----------------------------------------------------------------------
	// mask sweep
	// ----------------------------------------------------------------------

	// both generators start on the same pulse and run in lockstep,
	// so the busy flag of row 0 stands for the pair
	blockMaskGenerator maskRow0 (
		.clk               (clk),
		._resetRow         (_resetRow),
		._resetHead        (_resetHead),
		.rowDone           (rowDone),
		.rowMin            (rowMin0),
		.rowMax            (rowMax0),
		.blockPruningRatio (blockPruningRatio),
		.chunkScores       (chunkScores0),
		.chunkIndex        (chunkIndex0),
		.mask              (mask0),
		.maskBusy          (maskBusy)
	);

	blockMaskGenerator maskRow1 (
		.clk               (clk),
		._resetRow         (_resetRow),
		._resetHead        (_resetHead),
		.rowDone           (rowDone),
		.rowMin            (rowMin1),
		.rowMax            (rowMax1),
		.blockPruningRatio (blockPruningRatio),
		.chunkScores       (chunkScores1),
		.chunkIndex        (chunkIndex1),
		.mask              (mask1),
		.maskBusy          ()
	);

endmodule

/* testbench/pruneArray_properties.sv */
// sweep timing and reset properties of the pruning top level, attached to every pruneArray by bind
`timescale 1ns/1ps

module pruneArrayProperties
	import pruneArrayPkg::*;
(
	input logic clk,
	input logic _resetRow,
	input logic _resetHead,
	input logic scoreValid,
	input logic rowDone,
	input logic maskBusy,
	input logic pruneHead
);

	// ----------------------------------------------------------------------
	// sweep timing
	// ----------------------------------------------------------------------

	// the generators pick up the end of row pulse on the very next edge
	busyFollowsRowDone: assert property (
		@(posedge clk) disable iff (!_resetRow || !_resetHead)
		rowDone |=> $rose(maskBusy)
	)
	else
		$error("maskBusy did not rise one cycle after rowDone");

	// one chunk per cycle, four chunks per row
	busyLastsFourCycles: assert property (
		@(posedge clk) disable iff (!_resetRow || !_resetHead)
		$rose(maskBusy) |-> maskBusy ##1 maskBusy ##1 maskBusy ##1 maskBusy ##1 !maskBusy
	)
	else
		$error("maskBusy was not high for exactly four cycles");

	// there is no back-pressure, so the producer has to hold off during a sweep
	noScoresDuringSweep: assert property (
		@(posedge clk) disable iff (!_resetRow || !_resetHead)
		!(scoreValid && maskBusy)
	)
	else
		$error("scoreValid was high while the mask sweep was running");

	// ----------------------------------------------------------------------
	// reset behavior
	// ----------------------------------------------------------------------

	// either reset stops a sweep
	busyLowInReset: assert property (
		@(posedge clk)
		(!_resetRow || !_resetHead) |-> !maskBusy
	)
	else
		$error("maskBusy was high while a reset was asserted");

	// the pruning decision belongs to the head and only the head reset clears it
	pruneLowInHeadReset: assert property (
		@(posedge clk)
		!_resetHead |-> !pruneHead
	)
	else
		$error("pruneHead was high while the head reset was asserted");

endmodule

bind pruneArray pruneArrayProperties pruneChecks (
	.clk        (clk),
	._resetRow  (_resetRow),
	._resetHead (_resetHead),
	.scoreValid (scoreValid),
	.rowDone    (rowDone),
	.maskBusy   (maskBusy),
	.pruneHead  (pruneHead)
);

/* testbench/pruneArrayTb.sv */
// testbench of the pruning top level, sends random score tiles and checks masks and head results
`timescale 1ns/1ps
`include "pruneArray_params.svh"

module pruneArrayTb
	import pruneArrayPkg::*;
();

	localparam int HALF_PERIOD = 50;
	// 17 + 6 + 1 + 8 tiles over the four rows below
	localparam int TILES_SENT = 32;
	localparam int WATCHDOG_CYCLES = TILES_SENT * 10 + 100;

	logic   clk;
	logic   _resetRow;
	logic   _resetHead;
	logic   scoreValid;
	logic   endOfRow;
	logic   endOfHead;
	tile_t  scoresRow0;
	tile_t  scoresRow1;
	score_t headThreshold;
	ratio_t blockPruningRatio;
	mask_t  mask0;
	mask_t  mask1;
	logic   maskBusy;
	logic   pruneHead;
	score_t sumHeadFinal;

	// reference model state, index 0 and 1 are the two rows
	score_t modelEntries [2][`STORE_DEPTH];
	score_t modelMin [2];
	score_t modelMax [2];
	score_t modelSum;
	logic   modelPrune;
	int     modelCount;

	pruneArray i_pruneArray (
		.clk               (clk),
		._resetRow         (_resetRow),
		._resetHead        (_resetHead),
		.scoreValid        (scoreValid),
		.endOfRow          (endOfRow),
		.endOfHead         (endOfHead),
		.scoresRow0        (scoresRow0),
		.scoresRow1        (scoresRow1),
		.headThreshold     (headThreshold),
		.blockPruningRatio (blockPruningRatio),
		.mask0             (mask0),
		.mask1             (mask1),
		.maskBusy          (maskBusy),
		.pruneHead         (pruneHead),
		.sumHeadFinal      (sumHeadFinal)
	);

	initial
		clk = 1'b0;
	always
		#HALF_PERIOD clk = ~clk;

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------

	// the row reset empties the stores, the head reset also drops the head sum
	function automatic void resetModel(input logic headToo);
		for (int r = 0; r < 2; r++)
		begin
			for (int e = 0; e < `STORE_DEPTH; e++)
				modelEntries[r][e] = '0;
			modelMin[r] = '1;
			modelMax[r] = '0;
		end
		modelCount = 0;
		if (headToo)
		begin
			modelSum = '0;
			modelPrune = 1'b0;
		end
	endfunction

	// scores past the end of the store still count in min, max and sum
	function automatic void addTile(input int row, input tile_t tile);
		for (int k = 0; k < `TILE_SIZE; k++)
		begin
			if (modelCount + k < `STORE_DEPTH)
				modelEntries[row][modelCount + k] = tile[k];
			if (tile[k] < modelMin[row])
				modelMin[row] = tile[k];
			if (tile[k] > modelMax[row])
				modelMax[row] = tile[k];
			modelSum = modelSum + tile[k];
		end
	endfunction

	// keep a block when its score reaches min plus ratio eighths of the spread
	function automatic mask_t expectedMask(input int row, input ratio_t ratio);
		mask_t result;
		score_t threshold;
		logic [31:0] spreadTerm;
		spreadTerm = 32'(modelMax[row] - modelMin[row]) * 32'(ratio);
		threshold = modelMin[row] + score_t'(spreadTerm >> `RATIO_SHIFT);
		for (int e = 0; e < `STORE_DEPTH; e++)
			result[e] = (modelEntries[row][e] >= threshold);
		return result;
	endfunction

	// ----------------------------------------------------------------------
	// checking and stimulus
	// ----------------------------------------------------------------------

	task automatic checkValue(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		assert (got === expected)
		else
		begin
			$display("mismatch %s: got 0x%h expected 0x%h", name, got, expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	// idle state after a reset: full masks, no sweep, head decision kept unless head reset
	task automatic checkIdle();
		checkValue("mask0", 64'(mask0), {64{1'b1}});
		checkValue("mask1", 64'(mask1), {64{1'b1}});
		checkValue("maskBusy", 64'(maskBusy), 64'(0));
		checkValue("pruneHead", 64'(pruneHead), 64'(modelPrune));
	endtask

	// called on a falling edge, holds the reset for three cycles
	task automatic applyReset(input logic headToo);
		_resetRow = 1'b0;
		_resetHead = !headToo;
		resetModel(headToo);
		repeat (3) @(negedge clk);
		_resetRow = 1'b1;
		_resetHead = 1'b1;
		checkIdle();
	endtask

	// one strobe carrying a random tile for each row, scores kept to 12 bits
	task automatic sendTile(input logic lastOfRow, input logic lastOfHead,
			input logic zeroFirst, input logic pruneWanted);
		tile_t tile0;
		tile_t tile1;
		for (int k = 0; k < `TILE_SIZE; k++)
		begin
			tile0[k] = score_t'($urandom() & 32'hfff);
			tile1[k] = score_t'($urandom() & 32'hfff);
		end
		// a zero score pulls the row minimum and so the threshold down to zero
		if (zeroFirst)
			tile0[0] = '0;
		addTile(0, tile0);
		addTile(1, tile1);
		modelCount = modelCount + `TILE_SIZE;
		if (lastOfRow && lastOfHead)
		begin
			headThreshold = pruneWanted ? modelSum + 16'd1 : modelSum - 16'd1;
			modelPrune = (modelSum <= headThreshold);
		end
		scoreValid = 1'b1;
		endOfRow = lastOfRow;
		endOfHead = lastOfHead;
		scoresRow0 = tile0;
		scoresRow1 = tile1;
		@(negedge clk);
		scoreValid = 1'b0;
		endOfRow = 1'b0;
		endOfHead = 1'b0;
	endtask

	// the watchdog covers a sweep that never starts or never ends
	task automatic waitSweep();
		while (!maskBusy)
			@(negedge clk);
		while (maskBusy)
			@(negedge clk);
	endtask

	task automatic sendRow(input int tiles, input ratio_t ratio, input logic endHead,
			input logic zeroFirst, input logic pruneWanted);
		blockPruningRatio = ratio;
		for (int t = 0; t < tiles; t++)
			sendTile(t == tiles - 1, endHead && (t == tiles - 1), zeroFirst && (t == 0),
				pruneWanted);
		waitSweep();
		checkValue("mask0", 64'(mask0), 64'(expectedMask(0, ratio)));
		checkValue("mask1", 64'(mask1), 64'(expectedMask(1, ratio)));
		checkValue("sumHeadFinal", 64'(sumHeadFinal), 64'(modelSum));
		checkValue("pruneHead", 64'(pruneHead), 64'(modelPrune));
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------

	initial
	begin
		void'($urandom(32));
		_resetRow = 1'b0;
		_resetHead = 1'b0;
		scoreValid = 1'b0;
		endOfRow = 1'b0;
		endOfHead = 1'b0;
		scoresRow0 = '0;
		scoresRow1 = '0;
		headThreshold = '0;
		blockPruningRatio = '0;
		applyReset(1'b1);
		// full store, and the closing tile is dropped from the store but not from the statistics
		sendRow(17, 3'd5, 1'b0, 1'b0, 1'b0);
		// second row of the same head, ratio zero and a zero score in row 0
		applyReset(1'b0);
		sendRow(6, 3'd0, 1'b1, 1'b1, 1'b1);
		// a one-tile row whose sweep is cut short by the head reset, leaving full masks
		sendTile(1'b1, 1'b0, 1'b0, 1'b0);
		while (!maskBusy)
			@(negedge clk);
		applyReset(1'b1);
		// new head whose sum stays above its limit
		sendRow(8, 3'd7, 1'b1, 1'b0, 1'b0);
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

/* pruneArray.f */
+incdir+include
hw/pruneArrayPkg.sv
hw/rowImportanceTracker.sv
hw/importanceStore.sv
hw/blockMaskGenerator.sv
hw/pruneArray.sv
testbench/pruneArray_properties.sv
testbench/pruneArrayTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the pruneArray testbench with Verilator, runs it and decides pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module pruneArrayTb \
	-f pruneArray.f -o simPruneArray \
	&& ./obj_dir/simPruneArray > sim.log 2>&1 \
	|| { echo "build or simulation ended with an error"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "^TESTBENCH PASSED$" sim.log \
	&& echo "simulation result: pass" \
	|| { echo "simulation result: fail"; exit 1; }
